//--- build.f
hw/rv_core_pkg.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/result_select.sv
hw/exec_slice_top.sv
verif/exec_slice_tb.sv

//--- hw/alu_execute.sv
// operand select, ALU with word forms, word divide, branch compare and stage 2 registers
`timescale 1ns/1ps
`default_nettype none

module alu_execute import rv_core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  alu_op_e  i_alu_op,
  input  asrc_e    i_asrc,
  input  bsrc_e    i_bsrc,
  input  logic     i_word_cut,
  input  branch_e  i_branch,
  input  xlen_t    i_imm,
  input  logic     i_reg_we,
  input  reg_idx_t i_rd,
  input  logic     i_mem_wr,
  input  logic     i_mem_rd,
  input  mem_op_e  i_mem_op,
  input  xlen_t    i_pc,
  input  xlen_t    i_rs1_val,
  input  xlen_t    i_rs2_val,
  output logic     o_valid,
  output xlen_t    o_result,
  output logic     o_cond,
  output branch_e  o_branch,
  output xlen_t    o_pc,
  output xlen_t    o_imm,
  output xlen_t    o_rs1_val,
  output xlen_t    o_rs2_val,
  output reg_idx_t o_rd,
  output logic     o_reg_we,
  output logic     o_mem_wr,
  output logic     o_mem_rd,
  output mem_op_e  o_mem_op,
  output logic     o_ebreak,
  output logic     o_illegal
);

  xlen_t              op_a, op_b;
  logic [5:0]         shamt;
  xlen_t              srl_src, sra_src;
  logic signed [31:0] div_a, div_b, quot, rem;
  logic               div_zero, div_ovf;
  xlen_t              raw, result;
  logic               cond;

  assign op_a = (i_asrc == ASRC_PC) ? i_pc : i_rs1_val;

  always_comb begin
    case (i_bsrc)
      BSRC_RS2:    op_b = i_rs2_val;
      BSRC_IMM:    op_b = i_imm;
      BSRC_CONST4: op_b = 64'd4;
      default:     op_b = '0;
    endcase
  end

  // word shifts see only the low 32 bits of a
  assign shamt   = i_word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];
  assign srl_src = i_word_cut ? {32'b0, op_a[31:0]} : op_a;
  assign sra_src = i_word_cut ? {{32{op_a[31]}}, op_a[31:0]} : op_a;

  assign div_a    = op_a[31:0];
  assign div_b    = op_b[31:0];
  assign div_zero = (div_b == 32'sd0);
  assign div_ovf  = (div_a == 32'sh8000_0000) && (div_b == -32'sd1);
  assign quot     = div_zero ? -32'sd1 : (div_ovf ? div_a : div_a / div_b);
  assign rem      = div_zero ? div_a : (div_ovf ? 32'sd0 : div_a % div_b);

  always_comb begin
    case (i_alu_op)
      ALU_COPYIMM: raw = op_b;
      ALU_ADD:     raw = op_a + op_b;
      ALU_SUB:     raw = op_a - op_b;
      ALU_SLTU:    raw = {63'b0, op_a < op_b};
      ALU_XOR:     raw = op_a ^ op_b;
      ALU_AND:     raw = op_a & op_b;
      ALU_OR:      raw = op_a | op_b;
      ALU_SLL:     raw = op_a << shamt;
      ALU_SRL:     raw = srl_src >> shamt;
      ALU_SRA:     raw = $signed(sra_src) >>> shamt;
      ALU_MUL:     raw = op_a * op_b;  // low half only
      ALU_DIV:     raw = {{32{quot[31]}}, quot};
      ALU_REM:     raw = {{32{rem[31]}}, rem};
      default:     raw = '0;
    endcase
  end

  assign result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    case (i_branch)
      BR_EQ:   cond = (i_rs1_val == i_rs2_val);
      BR_NE:   cond = (i_rs1_val != i_rs2_val);
      BR_LT:   cond = ($signed(i_rs1_val) < $signed(i_rs2_val));
      BR_GE:   cond = ($signed(i_rs1_val) >= $signed(i_rs2_val));
      BR_LTU:  cond = (i_rs1_val < i_rs2_val);
      BR_GEU:  cond = (i_rs1_val >= i_rs2_val);
      default: cond = 1'b0;  // jumps resolved in stage 3
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid   <= 1'b0;
      o_reg_we  <= 1'b0;
      o_mem_wr  <= 1'b0;
      o_mem_rd  <= 1'b0;
      o_ebreak  <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_reg_we  <= i_valid & i_reg_we;
      o_mem_wr  <= i_valid & i_mem_wr;
      o_mem_rd  <= i_valid & i_mem_rd;
      o_ebreak  <= i_valid & (i_alu_op == ALU_EBREAK);
      o_illegal <= i_valid & (i_alu_op == ALU_INVALID);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_result  <= result;
      o_cond    <= cond;
      o_branch  <= i_branch;
      o_pc      <= i_pc;
      o_imm     <= i_imm;
      o_rs1_val <= i_rs1_val;
      o_rs2_val <= i_rs2_val;
      o_rd      <= i_rd;
      o_mem_op  <= i_mem_op;
    end
  end

endmodule

`default_nettype wire

//--- hw/exec_slice_top.sv
// top level of the decode, execute and result pipeline slice
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top import rv_core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  inst_t    i_inst,
  input  xlen_t    i_pc,
  input  xlen_t    i_rs1_val,
  input  xlen_t    i_rs2_val,
  output logic     o_valid,
  output logic     o_reg_we,
  output reg_idx_t o_rd,
  output xlen_t    o_wb_data,
  output xlen_t    o_next_pc,
  output logic     o_mem_rd,
  output logic     o_mem_wr,
  output xlen_t    o_mem_addr,
  output xlen_t    o_mem_wdata,
  output mem_op_e  o_mem_op,
  output logic     o_ebreak,
  output logic     o_illegal
);

  // decode to execute
  logic     d_valid, d_word_cut, d_reg_we, d_mem_wr, d_mem_rd;
  alu_op_e  d_alu_op;
  asrc_e    d_asrc;
  bsrc_e    d_bsrc;
  branch_e  d_branch;
  xlen_t    d_imm, d_pc, d_rs1_val, d_rs2_val;
  reg_idx_t d_rd;
  mem_op_e  d_mem_op;

  // execute to result
  logic     e_valid, e_cond, e_reg_we, e_mem_wr, e_mem_rd, e_ebreak, e_illegal;
  xlen_t    e_result, e_pc, e_imm, e_rs1_val, e_rs2_val;
  branch_e  e_branch;
  reg_idx_t e_rd;
  mem_op_e  e_mem_op;

  inst_decode u_decode (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_val  (i_rs1_val),
    .i_rs2_val  (i_rs2_val),
    .o_valid    (d_valid),
    .o_alu_op   (d_alu_op),
    .o_asrc     (d_asrc),
    .o_bsrc     (d_bsrc),
    .o_word_cut (d_word_cut),
    .o_branch   (d_branch),
    .o_imm      (d_imm),
    .o_reg_we   (d_reg_we),
    .o_rd       (d_rd),
    .o_mem_wr   (d_mem_wr),
    .o_mem_rd   (d_mem_rd),
    .o_mem_op   (d_mem_op),
    .o_pc       (d_pc),
    .o_rs1_val  (d_rs1_val),
    .o_rs2_val  (d_rs2_val)
  );

  alu_execute u_execute (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (d_valid),
    .i_alu_op   (d_alu_op),
    .i_asrc     (d_asrc),
    .i_bsrc     (d_bsrc),
    .i_word_cut (d_word_cut),
    .i_branch   (d_branch),
    .i_imm      (d_imm),
    .i_reg_we   (d_reg_we),
    .i_rd       (d_rd),
    .i_mem_wr   (d_mem_wr),
    .i_mem_rd   (d_mem_rd),
    .i_mem_op   (d_mem_op),
    .i_pc       (d_pc),
    .i_rs1_val  (d_rs1_val),
    .i_rs2_val  (d_rs2_val),
    .o_valid    (e_valid),
    .o_result   (e_result),
    .o_cond     (e_cond),
    .o_branch   (e_branch),
    .o_pc       (e_pc),
    .o_imm      (e_imm),
    .o_rs1_val  (e_rs1_val),
    .o_rs2_val  (e_rs2_val),
    .o_rd       (e_rd),
    .o_reg_we   (e_reg_we),
    .o_mem_wr   (e_mem_wr),
    .o_mem_rd   (e_mem_rd),
    .o_mem_op   (e_mem_op),
    .o_ebreak   (e_ebreak),
    .o_illegal  (e_illegal)
  );

  result_select u_result (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (e_valid),
    .i_result    (e_result),
    .i_cond      (e_cond),
    .i_branch    (e_branch),
    .i_pc        (e_pc),
    .i_imm       (e_imm),
    .i_rs1_val   (e_rs1_val),
    .i_rs2_val   (e_rs2_val),
    .i_rd        (e_rd),
    .i_reg_we    (e_reg_we),
    .i_mem_wr    (e_mem_wr),
    .i_mem_rd    (e_mem_rd),
    .i_mem_op    (e_mem_op),
    .i_ebreak    (e_ebreak),
    .i_illegal   (e_illegal),
    .o_valid     (o_valid),
    .o_reg_we    (o_reg_we),
    .o_rd        (o_rd),
    .o_wb_data   (o_wb_data),
    .o_next_pc   (o_next_pc),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_mem_op    (o_mem_op),
    .o_ebreak    (o_ebreak),
    .o_illegal   (o_illegal)
  );

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
// instruction decoder, immediate generation and stage 1 registers
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  inst_t    i_inst,
  input  xlen_t    i_pc,
  input  xlen_t    i_rs1_val,
  input  xlen_t    i_rs2_val,
  output logic     o_valid,
  output alu_op_e  o_alu_op,
  output asrc_e    o_asrc,
  output bsrc_e    o_bsrc,
  output logic     o_word_cut,
  output branch_e  o_branch,
  output xlen_t    o_imm,
  output logic     o_reg_we,
  output reg_idx_t o_rd,
  output logic     o_mem_wr,
  output logic     o_mem_rd,
  output mem_op_e  o_mem_op,
  output xlen_t    o_pc,
  output xlen_t    o_rs1_val,
  output xlen_t    o_rs2_val
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_u, imm_s, imm_b, imm_j;

  alu_op_e dec_alu_op;
  asrc_e   dec_asrc;
  bsrc_e   dec_bsrc;
  logic    dec_word_cut;
  branch_e dec_branch;
  xlen_t   dec_imm;
  logic    dec_reg_we, dec_mem_wr, dec_mem_rd;
  mem_op_e dec_mem_op;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    dec_alu_op   = ALU_INVALID;
    dec_asrc     = ASRC_RS1;
    dec_bsrc     = BSRC_RS2;
    dec_word_cut = 1'b0;
    dec_branch   = BR_NONE;
    dec_imm      = imm_i;
    dec_reg_we   = 1'b0;
    dec_mem_wr   = 1'b0;
    dec_mem_rd   = 1'b0;
    dec_mem_op   = MEM_NONE;
    case (opcode)
      OPC_LUI: begin
        dec_alu_op = ALU_COPYIMM;
        dec_bsrc   = BSRC_IMM;
        dec_imm    = imm_u;
        dec_reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        dec_alu_op = ALU_ADD;
        dec_asrc   = ASRC_PC;
        dec_bsrc   = BSRC_IMM;
        dec_imm    = imm_u;
        dec_reg_we = 1'b1;
      end
      OPC_JAL: begin
        dec_alu_op = ALU_ADD;  // link value pc+4
        dec_asrc   = ASRC_PC;
        dec_bsrc   = BSRC_CONST4;
        dec_imm    = imm_j;
        dec_branch = BR_JAL;
        dec_reg_we = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec_alu_op = ALU_ADD;
          dec_asrc   = ASRC_PC;
          dec_bsrc   = BSRC_CONST4;
          dec_branch = BR_JALR;
          dec_reg_we = 1'b1;
        end
      end
      OPC_BRANCH: begin
        dec_imm = imm_b;
        case (funct3)
          3'b000:  dec_branch = BR_EQ;
          3'b001:  dec_branch = BR_NE;
          3'b100:  dec_branch = BR_LT;
          3'b101:  dec_branch = BR_GE;
          3'b110:  dec_branch = BR_LTU;
          3'b111:  dec_branch = BR_GEU;
          default: dec_branch = BR_NONE;
        endcase
        if (dec_branch != BR_NONE) dec_alu_op = ALU_SUB;
      end
      OPC_LOAD: begin
        dec_bsrc   = BSRC_IMM;
        dec_mem_rd = 1'b1;
        dec_reg_we = 1'b1;
        case (funct3)
          3'b001:  dec_mem_op = MEM_SH;
          3'b101:  dec_mem_op = MEM_UH;
          3'b010:  dec_mem_op = MEM_SW;
          3'b100:  dec_mem_op = MEM_UB;
          3'b011:  dec_mem_op = MEM_D;
          default: dec_mem_op = MEM_NONE;
        endcase
        if (dec_mem_op != MEM_NONE) dec_alu_op = ALU_ADD;
      end
      OPC_STORE: begin
        dec_bsrc   = BSRC_IMM;
        dec_imm    = imm_s;
        dec_mem_wr = 1'b1;
        case (funct3)
          3'b000:  dec_mem_op = MEM_SB;  // store width only, sign is don't care
          3'b001:  dec_mem_op = MEM_SH;
          3'b010:  dec_mem_op = MEM_SW;
          3'b011:  dec_mem_op = MEM_D;
          default: dec_mem_op = MEM_NONE;
        endcase
        if (dec_mem_op != MEM_NONE) dec_alu_op = ALU_ADD;
      end
      OPC_OP_IMM: begin
        dec_bsrc   = BSRC_IMM;
        dec_reg_we = 1'b1;
        case (funct3)
          3'b000: dec_alu_op = ALU_ADD;
          3'b011: dec_alu_op = ALU_SLTU;
          3'b100: dec_alu_op = ALU_XOR;
          3'b111: dec_alu_op = ALU_AND;
          3'b001: if (funct7[6:1] == 6'b000000) dec_alu_op = ALU_SLL;
          3'b101: begin
            if (funct7[6:1] == 6'b000000) dec_alu_op = ALU_SRL;
            else if (funct7[6:1] == 6'b010000) dec_alu_op = ALU_SRA;
          end
          default: ;
        endcase
      end
      OPC_OP: begin
        dec_reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_alu_op = ALU_ADD;
          10'b0100000_000: dec_alu_op = ALU_SUB;
          10'b0000000_110: dec_alu_op = ALU_OR;
          10'b0000001_000: dec_alu_op = ALU_MUL;
          default: ;
        endcase
      end
      OPC_OP_IMM_32: begin
        dec_bsrc     = BSRC_IMM;
        dec_word_cut = 1'b1;
        dec_reg_we   = 1'b1;
        case ({funct7, funct3})
          10'b0000000_001: dec_alu_op = ALU_SLL;
          10'b0000000_101: dec_alu_op = ALU_SRL;
          10'b0100000_101: dec_alu_op = ALU_SRA;
          default: if (funct3 == 3'b000) dec_alu_op = ALU_ADD;  // addiw, funct7 is imm
        endcase
      end
      OPC_OP_32: begin
        dec_word_cut = 1'b1;
        dec_reg_we   = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_alu_op = ALU_ADD;
          10'b0100000_000: dec_alu_op = ALU_SUB;
          10'b0000000_001: dec_alu_op = ALU_SLL;
          10'b0000000_101: dec_alu_op = ALU_SRL;
          10'b0100000_101: dec_alu_op = ALU_SRA;
          10'b0000001_000: dec_alu_op = ALU_MUL;
          10'b0000001_100: dec_alu_op = ALU_DIV;
          10'b0000001_110: dec_alu_op = ALU_REM;
          default: ;
        endcase
      end
      OPC_SYSTEM: begin
        dec_bsrc = BSRC_IMM;
        if (funct3 == 3'b000 && i_inst[31:20] == 12'd1) dec_alu_op = ALU_EBREAK;
      end
      default: ;
    endcase
    // unmatched encodings never write
    if (dec_alu_op == ALU_INVALID) begin
      dec_reg_we = 1'b0;
      dec_mem_wr = 1'b0;
      dec_mem_rd = 1'b0;
      dec_mem_op = MEM_NONE;
      dec_branch = BR_NONE;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid  <= 1'b0;
      o_reg_we <= 1'b0;
      o_mem_wr <= 1'b0;
      o_mem_rd <= 1'b0;
    end else begin
      o_valid  <= i_valid;
      o_reg_we <= i_valid & dec_reg_we;
      o_mem_wr <= i_valid & dec_mem_wr;
      o_mem_rd <= i_valid & dec_mem_rd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_alu_op   <= dec_alu_op;
      o_asrc     <= dec_asrc;
      o_bsrc     <= dec_bsrc;
      o_word_cut <= dec_word_cut;
      o_branch   <= dec_branch;
      o_imm      <= dec_imm;
      o_rd       <= i_inst[11:7];
      o_mem_op   <= dec_mem_op;
      o_pc       <= i_pc;
      o_rs1_val  <= i_rs1_val;
      o_rs2_val  <= i_rs2_val;
    end
  end

endmodule

`default_nettype wire

//--- hw/result_select.sv
// writeback, next pc, memory request and status flags with stage 3 registers
`timescale 1ns/1ps
`default_nettype none

module result_select import rv_core_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  xlen_t    i_result,
  input  logic     i_cond,
  input  branch_e  i_branch,
  input  xlen_t    i_pc,
  input  xlen_t    i_imm,
  input  xlen_t    i_rs1_val,
  input  xlen_t    i_rs2_val,
  input  reg_idx_t i_rd,
  input  logic     i_reg_we,
  input  logic     i_mem_wr,
  input  logic     i_mem_rd,
  input  mem_op_e  i_mem_op,
  input  logic     i_ebreak,
  input  logic     i_illegal,
  output logic     o_valid,
  output logic     o_reg_we,
  output reg_idx_t o_rd,
  output xlen_t    o_wb_data,
  output xlen_t    o_next_pc,
  output logic     o_mem_rd,
  output logic     o_mem_wr,
  output xlen_t    o_mem_addr,
  output xlen_t    o_mem_wdata,
  output mem_op_e  o_mem_op,
  output logic     o_ebreak,
  output logic     o_illegal
);

  xlen_t pc_plus4, pc_target, jalr_target, next_pc;

  assign pc_plus4    = i_pc + 64'd4;
  assign pc_target   = i_pc + i_imm;
  assign jalr_target = (i_rs1_val + i_imm) & ~64'd1;

  always_comb begin
    case (i_branch)
      BR_NONE: next_pc = pc_plus4;
      BR_JAL:  next_pc = pc_target;
      BR_JALR: next_pc = jalr_target;
      default: next_pc = i_cond ? pc_target : pc_plus4;  // conditional branches
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid   <= 1'b0;
      o_reg_we  <= 1'b0;
      o_mem_rd  <= 1'b0;
      o_mem_wr  <= 1'b0;
      o_mem_op  <= MEM_NONE;
      o_ebreak  <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_reg_we  <= i_valid & i_reg_we & (i_rd != 5'd0) & ~i_illegal;  // x0 stays zero
      o_mem_rd  <= i_valid & i_mem_rd;
      o_mem_wr  <= i_valid & i_mem_wr;
      o_mem_op  <= i_valid ? i_mem_op : MEM_NONE;
      o_ebreak  <= i_valid & i_ebreak;
      o_illegal <= i_valid & i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd        <= i_rd;
      o_wb_data   <= i_result;  // already pc+4 for jumps
      o_next_pc   <= next_pc;
      o_mem_addr  <= i_result;
      o_mem_wdata <= i_rs2_val;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_core_pkg.sv
// shared widths, ALU op, branch kind and memory op enums, source selects, opcode constants
`default_nettype none

package rv_core_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [4:0] {
    ALU_ADD     = 5'b00000,
    ALU_SLL     = 5'b00001,
    ALU_COPYIMM = 5'b00011,
    ALU_XOR     = 5'b00100,
    ALU_SRL     = 5'b00101,
    ALU_OR      = 5'b00110,
    ALU_AND     = 5'b00111,
    ALU_SUB     = 5'b01000,
    ALU_SLTU    = 5'b01010,
    ALU_SRA     = 5'b01101,
    ALU_DIV     = 5'b11011,  // signed, word only
    ALU_MUL     = 5'b11100,
    ALU_REM     = 5'b11101,  // signed, word only
    ALU_EBREAK  = 5'b11110,
    ALU_INVALID = 5'b11111
  } alu_op_e;

  // signed and unsigned compares kept apart
  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_JAL  = 4'd1,
    BR_JALR = 4'd2,
    BR_EQ   = 4'd3,
    BR_NE   = 4'd4,
    BR_LT   = 4'd5,
    BR_GE   = 4'd6,
    BR_LTU  = 4'd7,
    BR_GEU  = 4'd8
  } branch_e;

  typedef enum logic [2:0] {
    MEM_SB   = 3'b000,
    MEM_UB   = 3'b001,
    MEM_SH   = 3'b010,
    MEM_UH   = 3'b011,
    MEM_SW   = 3'b100,
    MEM_UW   = 3'b101,
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic {
    ASRC_RS1 = 1'b0,
    ASRC_PC  = 1'b1
  } asrc_e;

  typedef enum logic [1:0] {
    BSRC_RS2    = 2'b00,
    BSRC_IMM    = 2'b01,
    BSRC_CONST4 = 2'b10
  } bsrc_e;

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pipeline slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module exec_slice_tb \
  -f build.f

# the simulator status is ignored here, the log decides
./obj_dir/Vexec_slice_tb | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- verif/exec_slice_patterns.txt
# name gap inst pc rs1 rs2 | reg_we rd wb_data next_pc mem_rd mem_wr mem_addr mem_wdata mem_op ebreak illegal
# all hex; gap 1 allows idle cycles before the vector, gap 0 issues it right after the previous one
add_ovf 1 002082b3 1000 7fffffffffffffff 1 1 5 8000000000000000 1004 0 0 0 0 7 0 0
sub 1 402082b3 1000 5 7 1 5 fffffffffffffffe 1004 0 0 0 0 7 0 0
addi_neg 1 fff08293 1000 0 0 1 5 ffffffffffffffff 1004 0 0 0 0 7 0 0
sltiu_lt 1 0050b293 1000 3 0 1 5 1 1004 0 0 0 0 7 0 0
sltiu_max 1 fff0b293 1000 ffffffffffffffff 0 1 5 0 1004 0 0 0 0 7 0 0
xori_not 1 fff0c293 1000 ff00ff00ff00ff 0 1 5 ff00ff00ff00ff00 1004 0 0 0 0 7 0 0
andi 1 7ff0f293 1000 fffffffffffff123 0 1 5 123 1004 0 0 0 0 7 0 0
or 1 0020e2b3 1000 f0f0 0f0f 1 5 ffff 1004 0 0 0 0 7 0 0
lui_neg 1 800002b7 1000 0 0 1 5 ffffffff80000000 1004 0 0 0 0 7 0 0
auipc 1 00001297 1000 0 0 1 5 2000 1004 0 0 0 0 7 0 0
auipc_neg 1 fffff297 1000 0 0 1 5 0 1004 0 0 0 0 7 0 0
add_x0 1 00208033 1000 1 2 0 0 0 1004 0 0 0 0 7 0 0
# shifts
slli4 1 00409293 1000 0123456789abcdef 0 1 5 123456789abcdef0 1004 0 0 0 0 7 0 0
srli8 1 0080d293 1000 8000000000000000 0 1 5 0080000000000000 1004 0 0 0 0 7 0 0
srai8 1 4080d293 1000 8000000000000000 0 1 5 ff80000000000000 1004 0 0 0 0 7 0 0
# word forms and multiply or divide, issued back to back
addiw 1 0010829b 1000 7fffffff 0 1 5 ffffffff80000000 1004 0 0 0 0 7 0 0
addw 0 002082bb 1000 123456780fffffff 1 1 5 10000000 1004 0 0 0 0 7 0 0
sllw 0 002092bb 1000 1 3f 1 5 ffffffff80000000 1004 0 0 0 0 7 0 0
srliw 0 0040d29b 1000 ffffffff80000000 0 1 5 8000000 1004 0 0 0 0 7 0 0
sraw 0 4020d2bb 1000 80000000 4 1 5 fffffffff8000000 1004 0 0 0 0 7 0 0
mul 0 022082b3 1000 100000001 100000001 1 5 200000001 1004 0 0 0 0 7 0 0
mulw 0 022082bb 1000 8000 10000 1 5 ffffffff80000000 1004 0 0 0 0 7 0 0
divw 0 0220c2bb 1000 fffffffffffffff9 2 1 5 fffffffffffffffd 1004 0 0 0 0 7 0 0
remw 0 0220e2bb 1000 fffffffffffffff9 2 1 5 ffffffffffffffff 1004 0 0 0 0 7 0 0
divw_zero 0 0220c2bb 1000 5 100000000 1 5 ffffffffffffffff 1004 0 0 0 0 7 0 0
remw_zero 0 0220e2bb 1000 fffffff9 0 1 5 fffffffffffffff9 1004 0 0 0 0 7 0 0
divw_ovf 0 0220c2bb 1000 80000000 ffffffff 1 5 ffffffff80000000 1004 0 0 0 0 7 0 0
remw_ovf 0 0220e2bb 1000 80000000 ffffffff 1 5 0 1004 0 0 0 0 7 0 0
# branches, taken and not taken, signed and unsigned operands
beq_t 1 00208863 1000 5 5 0 0 0 1010 0 0 0 0 7 0 0
beq_n 1 00208863 1000 5 6 0 0 0 1004 0 0 0 0 7 0 0
bne_t 1 fe2098e3 1000 5 6 0 0 0 ff0 0 0 0 0 7 0 0
bne_n 1 00209863 1000 5 5 0 0 0 1004 0 0 0 0 7 0 0
blt_t 1 0020c863 1000 ffffffffffffffff 1 0 0 0 1010 0 0 0 0 7 0 0
bltu_n 1 0020e863 1000 ffffffffffffffff 1 0 0 0 1004 0 0 0 0 7 0 0
bge_n 1 0020d863 1000 ffffffffffffffff 1 0 0 0 1004 0 0 0 0 7 0 0
bgeu_t 1 0020f863 1000 ffffffffffffffff 1 0 0 0 1010 0 0 0 0 7 0 0
blt_n 1 0020c863 1000 1 ffffffffffffffff 0 0 0 1004 0 0 0 0 7 0 0
bltu_t 1 0020e863 1000 1 ffffffffffffffff 0 0 0 1010 0 0 0 0 7 0 0
bge_t 1 0020d863 1000 1 ffffffffffffffff 0 0 0 1010 0 0 0 0 7 0 0
bgeu_n 1 0020f863 1000 1 ffffffffffffffff 0 0 0 1004 0 0 0 0 7 0 0
# jumps
jal_fwd 1 100000ef 2000 0 0 1 1 2004 2100 0 0 0 0 7 0 0
jal_back 1 ff9ff0ef 2000 0 0 1 1 2004 1ff8 0 0 0 0 7 0 0
jalr 1 005082e7 2000 3000 0 1 5 2004 3004 0 0 0 0 7 0 0
jal_x0 1 1000006f 2000 0 0 0 0 0 2100 0 0 0 0 7 0 0
# loads and stores
lh 1 00809283 1000 8000 0 1 5 8008 1004 1 0 8008 0 2 0 0
lhu 1 0080d283 1000 8000 0 1 5 8008 1004 1 0 8008 0 3 0 0
lw 1 0080a283 1000 8000 0 1 5 8008 1004 1 0 8008 0 4 0 0
lbu 1 0080c283 1000 8000 0 1 5 8008 1004 1 0 8008 0 1 0 0
ld_neg 1 ff80b283 1000 8000 0 1 5 7ff8 1004 1 0 7ff8 0 6 0 0
sb 1 00208823 1000 8000 1122334455667788 0 0 0 1004 0 1 8010 1122334455667788 0 0 0
sh 0 00209823 1000 8000 1122334455667788 0 0 0 1004 0 1 8010 1122334455667788 2 0 0
sw 0 0020a823 1000 8000 1122334455667788 0 0 0 1004 0 1 8010 1122334455667788 4 0 0
sd_neg 0 fe20be23 1000 8000 1122334455667788 0 0 0 1004 0 1 7ffc 1122334455667788 6 0 0
# ebreak and illegal encodings
ebreak 1 00100073 1000 0 0 0 0 0 1004 0 0 0 0 7 1 0
illegal 1 000002ff 1000 0 0 0 0 0 1004 0 0 0 0 7 0 1
ecall 1 00000073 1000 0 0 0 0 0 1004 0 0 0 0 7 0 1

//--- verif/exec_slice_tb.sv
// testbench: pattern file reader, stimulus driver, result checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module exec_slice_tb import rv_core_pkg::*; ();

  localparam int    MAX_VEC      = 64;
  localparam string PATTERN_FILE = "verif/exec_slice_patterns.txt";

  typedef struct {
    logic [127:0] name;
    logic         reg_we;
    reg_idx_t     rd;
    xlen_t        wb_data;
    xlen_t        next_pc;
    logic         mem_rd;
    logic         mem_wr;
    xlen_t        mem_addr;
    xlen_t        mem_wdata;
    mem_op_e      mem_op;
    logic         ebreak;
    logic         illegal;
    int           due;  // negedge count when the result must show
  } expect_t;

  logic     clk;
  logic     rst_n;
  logic     valid;
  inst_t    inst;
  xlen_t    pc, rs1_val, rs2_val;
  logic     res_valid, res_reg_we, res_mem_rd, res_mem_wr, res_ebreak, res_illegal;
  reg_idx_t res_rd;
  xlen_t    res_wb_data, res_next_pc, res_mem_addr, res_mem_wdata;
  mem_op_e  res_mem_op;

  inst_t   vec_inst [MAX_VEC];
  xlen_t   vec_pc [MAX_VEC];
  xlen_t   vec_rs1 [MAX_VEC];
  xlen_t   vec_rs2 [MAX_VEC];
  logic    vec_gap [MAX_VEC];
  expect_t vec_exp [MAX_VEC];
  expect_t exp_q [$];
  expect_t cur;
  int      num_vec = 0;
  int      cycle = 0;  // negedges seen

  exec_slice_top i_dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_valid     (valid),
    .i_inst      (inst),
    .i_pc        (pc),
    .i_rs1_val   (rs1_val),
    .i_rs2_val   (rs2_val),
    .o_valid     (res_valid),
    .o_reg_we    (res_reg_we),
    .o_rd        (res_rd),
    .o_wb_data   (res_wb_data),
    .o_next_pc   (res_next_pc),
    .o_mem_rd    (res_mem_rd),
    .o_mem_wr    (res_mem_wr),
    .o_mem_addr  (res_mem_addr),
    .o_mem_wdata (res_mem_wdata),
    .o_mem_op    (res_mem_op),
    .o_ebreak    (res_ebreak),
    .o_illegal   (res_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_xlen(input logic [127:0] name, input string what,
                            input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %0s %s: expected %h, actual %h", name, what, exp, act));
    end
  endtask

  task automatic check_rd(input logic [127:0] name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %0s rd: expected x%0d, actual x%0d", name, exp, act));
    end
  endtask

  task automatic check_mem_op(input logic [127:0] name, input mem_op_e exp, input mem_op_e act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %0s mem_op: expected %s, actual %s",
                         name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input logic [127:0] name, input string what,
                            input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %0s %s: expected %b, actual %b", name, what, exp, act));
    end
  endtask

  task automatic check_latency(input logic [127:0] name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("MISMATCH %0s result cycle: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_result(input expect_t e);
    check_latency(e.name, e.due, cycle);
    check_flag(e.name, "reg_we", e.reg_we, res_reg_we);
    if (e.reg_we) begin
      check_rd(e.name, e.rd, res_rd);
      check_xlen(e.name, "wb_data", e.wb_data, res_wb_data);
    end
    check_xlen(e.name, "next_pc", e.next_pc, res_next_pc);
    check_flag(e.name, "mem_rd", e.mem_rd, res_mem_rd);
    check_flag(e.name, "mem_wr", e.mem_wr, res_mem_wr);
    if (e.mem_rd || e.mem_wr) begin
      check_xlen(e.name, "mem_addr", e.mem_addr, res_mem_addr);
    end
    if (e.mem_wr) begin
      check_xlen(e.name, "mem_wdata", e.mem_wdata, res_mem_wdata);
    end
    check_mem_op(e.name, e.mem_op, res_mem_op);
    check_flag(e.name, "ebreak", e.ebreak, res_ebreak);
    check_flag(e.name, "illegal", e.illegal, res_illegal);
  endtask

  task automatic read_patterns();
    int           fd;
    int           n;
    string        line;
    logic [127:0] name;
    logic [63:0]  gap, ins, vpc, rs1, rs2, we, rd, wb, npc;
    logic [63:0]  mrd, mwr, addr, wdata, mop, eb, il;
    expect_t      e;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      fail_run("could not open the pattern file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != 8'h23) begin  // skip blank and comment lines
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, gap, ins, vpc, rs1, rs2, we, rd, wb, npc,
                    mrd, mwr, addr, wdata, mop, eb, il);
        if (n != 17 || num_vec == MAX_VEC) begin
          fail_run($sformatf("bad or surplus pattern line: %s", line));
        end
        vec_gap[num_vec]  = gap[0];
        vec_inst[num_vec] = ins[31:0];
        vec_pc[num_vec]   = vpc;
        vec_rs1[num_vec]  = rs1;
        vec_rs2[num_vec]  = rs2;
        e.name      = name;
        e.reg_we    = we[0];
        e.rd        = rd[4:0];
        e.wb_data   = wb;
        e.next_pc   = npc;
        e.mem_rd    = mrd[0];
        e.mem_wr    = mwr[0];
        e.mem_addr  = addr;
        e.mem_wdata = wdata;
        e.mem_op    = mem_op_e'(mop[2:0]);
        e.ebreak    = eb[0];
        e.illegal   = il[0];
        e.due       = 0;
        vec_exp[num_vec] = e;
        num_vec++;
      end
    end
    $fclose(fd);
    if (num_vec == 0) begin
      fail_run("the pattern file holds no vectors");
    end
  endtask

  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!rst_n) begin
      check_flag("reset", "valid", 1'b0, res_valid);
      check_flag("reset", "reg_we", 1'b0, res_reg_we);
      check_flag("reset", "mem_rd", 1'b0, res_mem_rd);
      check_flag("reset", "mem_wr", 1'b0, res_mem_wr);
      check_flag("reset", "ebreak", 1'b0, res_ebreak);
      check_flag("reset", "illegal", 1'b0, res_illegal);
      check_mem_op("reset", MEM_NONE, res_mem_op);
    end else if (res_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("a result came out with no instruction pending");
      end else begin
        cur = exp_q.pop_front();
        check_result(cur);
      end
    end else begin
      // a bubble never writes
      check_flag("bubble", "reg_we", 1'b0, res_reg_we);
      check_flag("bubble", "mem_rd", 1'b0, res_mem_rd);
      check_flag("bubble", "mem_wr", 1'b0, res_mem_wr);
      check_flag("bubble", "ebreak", 1'b0, res_ebreak);
      check_flag("bubble", "illegal", 1'b0, res_illegal);
    end
  end

  initial begin
    int      gap;
    int      v;
    expect_t e;
    rst_n   <= 1'b0;
    valid   <= 1'b0;
    inst    <= '0;
    pc      <= '0;
    rs1_val <= '0;
    rs2_val <= '0;
    void'($urandom(52));
    read_patterns();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (v = 0; v < num_vec; v++) begin
      if (vec_gap[v]) begin
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge clk);
          valid <= 1'b0;
        end
      end
      @(posedge clk);
      valid   <= 1'b1;
      inst    <= vec_inst[v];
      pc      <= vec_pc[v];
      rs1_val <= vec_rs1[v];
      rs2_val <= vec_rs2[v];
      e = vec_exp[v];
      e.due = cycle + 4;  // sampled next edge, then three register stages
      exp_q.push_back(e);
    end
    @(posedge clk);
    valid <= 1'b0;
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d instructions never produced a result", exp_q.size()));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  // watchdog sized from the vector count
  initial begin
    wait (num_vec > 0);
    repeat (num_vec * 4 + 20) @(posedge clk);
    fail_run("timeout, the run did not finish in the allowed number of cycles");
  end

endmodule

`default_nettype wire
